// ==== decode_cfg.svh ====
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

// one fixed-point instruction word
`define INSTR_WIDTH 32

// effective address and full GPR width
`define ADDR_WIDTH 64

// GPR index field
`define REG_WIDTH 5

//////////////////////////////////////////////////
// trap handling
//////////////////////////////////////////////////

// cycles of stall after an illegal word
`define FLUSH_CYCLES 4

`endif

// ==== decodePkg.sv ====
`default_nettype none

package decodePkg;

	`include "decode_cfg.svh"

	//////////////////////////////////////////////////
	// vector types, bit 0 is the MSB
	//////////////////////////////////////////////////

	typedef logic [0:`INSTR_WIDTH-1] instrT;
	typedef logic [0:`ADDR_WIDTH-1] addrT;
	typedef logic [0:`REG_WIDTH-1] regIdxT;

	// primary and extended opcode fields
	typedef logic [0:5] opcodeT;
	typedef logic [0:9] xOpcodeT;

	// immediate extended to register width
	typedef logic [0:`ADDR_WIDTH-1] immT;
	// raw D/DS field as found in the word
	typedef logic [0:15] rawImmT;

	typedef logic [0:2] fuCodeT;
	typedef logic [0:4] formatT;

	//////////////////////////////////////////////////
	// dispatch codes
	//////////////////////////////////////////////////

	// functional unit IDs seen by dispatch
	localparam fuCodeT FX_UNIT = 3'd0;
	localparam fuCodeT LDST_UNIT = 3'd2;

	// format indices, same numbering as the full decoder
	localparam formatT FMT_D = 5'd3;
	localparam formatT FMT_DS = 5'd5;
	localparam formatT FMT_X = 5'd15;
	localparam formatT FMT_XO = 5'd19;

	// illegal-instruction controller
	typedef enum logic [1:0]
	{
		ctrlRun,
		ctrlSquash,
		ctrlFlush
	} ctrlStateT;

endpackage

`default_nettype wire

// ==== formatIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// registered claim of one stage-one decoder
interface formatIf;

	logic claim;
	decodePkg::formatT fmt;
	decodePkg::regIdxT reg1;
	decodePkg::regIdxT reg2;
	decodePkg::regIdxT reg3;
	logic reg1Valid;
	logic reg2Valid;
	logic reg3Valid;
	// immediate and how stage two shapes it
	decodePkg::rawImmT rawImm;
	logic immSigned;
	logic immShift16;
	logic immIsDs;
	logic reg2ValOrZero;
	decodePkg::xOpcodeT xOpcode;
	logic xOpcodeValid;
	decodePkg::fuCodeT fuCode;
	// XO only, OE and Rc
	logic oe;
	logic rc;

	modport decoder (output claim, fmt, reg1, reg2, reg3, reg1Valid, reg2Valid, reg3Valid,
		rawImm, immSigned, immShift16, immIsDs, reg2ValOrZero, xOpcode, xOpcodeValid,
		fuCode, oe, rc);

	modport mux (input claim, fmt, reg1, reg2, reg3, reg1Valid, reg2Valid, reg3Valid,
		rawImm, immSigned, immShift16, immIsDs, reg2ValOrZero, xOpcode, xOpcodeValid,
		fuCode, oe, rc);

endinterface

`default_nettype wire

// ==== dFormatDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module dFormatDecoder
(
	input wire clock_i,
	input wire rstN_i,
	input wire capture_i,
	input wire decodePkg::instrT instruction_i,
	formatIf.decoder claim
);

	localparam decodePkg::opcodeT OP_ADDI = 6'd14;
	localparam decodePkg::opcodeT OP_ADDIS = 6'd15;
	localparam decodePkg::opcodeT OP_ORI = 6'd24;
	localparam decodePkg::opcodeT OP_LWZ = 6'd32;
	localparam decodePkg::opcodeT OP_STW = 6'd36;
	localparam decodePkg::opcodeT OP_LD = 6'd58;

	decodePkg::opcodeT opcode;
	logic known;

	assign opcode = instruction_i[0:5];
	// ld is the only DS word here, sub-opcode must be 0
	assign known = (opcode == OP_ADDI) || (opcode == OP_ADDIS) || (opcode == OP_ORI) ||
		(opcode == OP_LWZ) || (opcode == OP_STW) ||
		((opcode == OP_LD) && (instruction_i[30:31] == 2'b00));

	// claim is control state
	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
			claim.claim <= 1'b0;
		else if (capture_i)
			claim.claim <= known;
	end

	// field extraction
	always_ff @(posedge clock_i)
	begin
		if (capture_i)
		begin
			claim.fmt <= (opcode == OP_LD) ? decodePkg::FMT_DS : decodePkg::FMT_D;
			claim.reg1 <= instruction_i[6:10];
			claim.reg2 <= instruction_i[11:15];
			claim.reg3 <= '0;
			claim.reg1Valid <= 1'b1;
			claim.reg2Valid <= 1'b1;
			claim.reg3Valid <= 1'b0;
			claim.rawImm <= instruction_i[16:31];
			// ori takes UI, everything else SI or DS
			claim.immSigned <= (opcode != OP_ORI);
			claim.immShift16 <= (opcode == OP_ADDIS);
			claim.immIsDs <= (opcode == OP_LD);
			// RA|0 for adds and memory ops
			claim.reg2ValOrZero <= (opcode != OP_ORI);
			claim.xOpcode <= '0;
			claim.xOpcodeValid <= 1'b0;
			claim.fuCode <= ((opcode == OP_LWZ) || (opcode == OP_STW) || (opcode == OP_LD)) ?
				decodePkg::LDST_UNIT : decodePkg::FX_UNIT;
			claim.oe <= 1'b0;
			claim.rc <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== xFormatDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module xFormatDecoder
(
	input wire clock_i,
	input wire rstN_i,
	input wire capture_i,
	input wire decodePkg::instrT instruction_i,
	formatIf.decoder claim
);

	localparam decodePkg::opcodeT OP_EXT = 6'd31;

	// X form, 10-bit extended opcodes
	localparam decodePkg::xOpcodeT XOP_AND = 10'd28;
	localparam decodePkg::xOpcodeT XOP_OR = 10'd444;
	localparam decodePkg::xOpcodeT XOP_LWZX = 10'd23;
	// XO form, 9-bit extended opcodes
	localparam logic [0:8] XOOP_ADD = 9'd266;
	localparam logic [0:8] XOOP_SUBF = 9'd40;

	decodePkg::xOpcodeT xo10;
	logic [0:8] xo9;
	logic isX;
	logic isXo;

	assign xo10 = instruction_i[21:30];
	// bit 21 is OE in XO form
	assign xo9 = instruction_i[22:30];

	assign isX = (instruction_i[0:5] == OP_EXT) &&
		((xo10 == XOP_AND) || (xo10 == XOP_OR) || (xo10 == XOP_LWZX));
	assign isXo = (instruction_i[0:5] == OP_EXT) && !isX &&
		((xo9 == XOOP_ADD) || (xo9 == XOOP_SUBF));

	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
			claim.claim <= 1'b0;
		else if (capture_i)
			claim.claim <= isX || isXo;
	end

	always_ff @(posedge clock_i)
	begin
		if (capture_i)
		begin
			claim.fmt <= isXo ? decodePkg::FMT_XO : decodePkg::FMT_X;
			// RT/RS, RA, RB
			claim.reg1 <= instruction_i[6:10];
			claim.reg2 <= instruction_i[11:15];
			claim.reg3 <= instruction_i[16:20];
			claim.reg1Valid <= 1'b1;
			claim.reg2Valid <= 1'b1;
			claim.reg3Valid <= 1'b1;
			claim.rawImm <= '0;
			claim.immSigned <= 1'b0;
			claim.immShift16 <= 1'b0;
			claim.immIsDs <= 1'b0;
			claim.reg2ValOrZero <= isX && (xo10 == XOP_LWZX);
			claim.xOpcode <= isXo ? {1'b0, xo9} : xo10;
			claim.xOpcodeValid <= 1'b1;
			claim.fuCode <= (isX && (xo10 == XOP_LWZX)) ?
				decodePkg::LDST_UNIT : decodePkg::FX_UNIT;
			claim.oe <= isXo && instruction_i[21];
			claim.rc <= isXo && instruction_i[31];
		end
	end

endmodule

`default_nettype wire

// ==== decodeStage2.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage2
(
	input wire clock_i,
	input wire rstN_i,
	input wire stage1Valid_i,
	input wire kill_i,
	input wire decodePkg::addrT stage1Address_i,
	input wire decodePkg::opcodeT stage1Opcode_i,
	formatIf.mux dClaim,
	formatIf.mux xClaim,
	output logic enable_o,
	output decodePkg::immT imm_o,
	output logic immEnable_o,
	output decodePkg::regIdxT reg1_o,
	output decodePkg::regIdxT reg2_o,
	output decodePkg::regIdxT reg3_o,
	output logic reg1Enable_o,
	output logic reg2Enable_o,
	output logic reg3Enable_o,
	output logic reg2ValOrZero_o,
	output logic bit1_o,
	output logic bit2_o,
	output logic bit1Enable_o,
	output logic bit2Enable_o,
	output decodePkg::addrT instructionAddress_o,
	output decodePkg::opcodeT opcode_o,
	output decodePkg::xOpcodeT xOpcode_o,
	output logic xOpcodeEnable_o,
	output decodePkg::fuCodeT functionalUnitCode_o,
	output decodePkg::formatT instructionFormat_o
);

	localparam int ImmW = $bits(decodePkg::immT);
	localparam int RawW = $bits(decodePkg::rawImmT);
	// DS displacement is the raw field minus its two sub-opcode bits
	localparam int DsW = RawW - 2;

	logic useD;
	logic recordValid;
	decodePkg::rawImmT rawImm;
	decodePkg::immT immExt;

	assign useD = dClaim.claim;
	assign recordValid = stage1Valid_i && (dClaim.claim || xClaim.claim) && !kill_i;
	assign rawImm = useD ? dClaim.rawImm : xClaim.rawImm;

	//////////////////////////////////////////////////
	// implicit immediate operations
	//////////////////////////////////////////////////
	always_comb
	begin
		if (useD ? dClaim.immIsDs : xClaim.immIsDs)
			immExt = {{(ImmW-DsW-2){rawImm[0]}}, rawImm[0:DsW-1], 2'b00};
		else if (useD ? dClaim.immShift16 : xClaim.immShift16)
			immExt = {{(ImmW-2*RawW){rawImm[0]}}, rawImm, {RawW{1'b0}}};
		else if (useD ? dClaim.immSigned : xClaim.immSigned)
			immExt = {{(ImmW-RawW){rawImm[0]}}, rawImm};
		else
			immExt = {{(ImmW-RawW){1'b0}}, rawImm};
	end

	//////////////////////////////////////////////////
	// output record
	//////////////////////////////////////////////////

	// valid and enable flags
	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			enable_o <= 1'b0;
			immEnable_o <= 1'b0;
			reg1Enable_o <= 1'b0;
			reg2Enable_o <= 1'b0;
			reg3Enable_o <= 1'b0;
			bit1Enable_o <= 1'b0;
			bit2Enable_o <= 1'b0;
			xOpcodeEnable_o <= 1'b0;
		end
		else
		begin
			enable_o <= recordValid;
			// only D and DS words carry an immediate
			immEnable_o <= recordValid && useD;
			reg1Enable_o <= recordValid && (useD ? dClaim.reg1Valid : xClaim.reg1Valid);
			reg2Enable_o <= recordValid && (useD ? dClaim.reg2Valid : xClaim.reg2Valid);
			reg3Enable_o <= recordValid && (useD ? dClaim.reg3Valid : xClaim.reg3Valid);
			bit1Enable_o <= recordValid && !useD && (xClaim.fmt == decodePkg::FMT_XO);
			bit2Enable_o <= recordValid && !useD && (xClaim.fmt == decodePkg::FMT_XO);
			xOpcodeEnable_o <= recordValid &&
				(useD ? dClaim.xOpcodeValid : xClaim.xOpcodeValid);
		end
	end

	// payload, held between records
	always_ff @(posedge clock_i)
	begin
		if (recordValid)
		begin
			imm_o <= immExt;
			reg1_o <= useD ? dClaim.reg1 : xClaim.reg1;
			reg2_o <= useD ? dClaim.reg2 : xClaim.reg2;
			reg3_o <= useD ? dClaim.reg3 : xClaim.reg3;
			reg2ValOrZero_o <= useD ? dClaim.reg2ValOrZero : xClaim.reg2ValOrZero;
			bit1_o <= useD ? dClaim.oe : xClaim.oe;
			bit2_o <= useD ? dClaim.rc : xClaim.rc;
			instructionAddress_o <= stage1Address_i;
			opcode_o <= stage1Opcode_i;
			xOpcode_o <= useD ? dClaim.xOpcode : xClaim.xOpcode;
			functionalUnitCode_o <= useD ? dClaim.fuCode : xClaim.fuCode;
			instructionFormat_o <= useD ? dClaim.fmt : xClaim.fmt;
		end
	end

endmodule

`default_nettype wire

// ==== decodeControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeControl
(
	input wire clock_i,
	input wire rstN_i,
	input wire illegal_i,
	input wire decodePkg::addrT stage1Address_i,
	input wire timerDone_i,
	output logic timerLoad_o,
	output logic squash_o,
	output logic trap_o,
	output decodePkg::addrT trapAddress_o,
	output logic stall_o
);

	decodePkg::ctrlStateT state;
	decodePkg::ctrlStateT nextState;

	// illegal word in stage one, kill the capture on this edge
	assign squash_o = (state == decodePkg::ctrlRun) && illegal_i;
	assign timerLoad_o = squash_o;
	assign stall_o = (state != decodePkg::ctrlRun);

	always_comb
	begin
		nextState = state;
		case (state)
			decodePkg::ctrlRun:
				if (illegal_i)
					nextState = decodePkg::ctrlSquash;
			decodePkg::ctrlSquash:
				nextState = decodePkg::ctrlFlush;
			decodePkg::ctrlFlush:
				if (timerDone_i)
					nextState = decodePkg::ctrlRun;
			default:
				nextState = decodePkg::ctrlRun;
		endcase
	end

	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
		begin
			state <= decodePkg::ctrlRun;
			trap_o <= 1'b0;
		end
		else
		begin
			state <= nextState;
			// one-cycle pulse toward the trap handler
			trap_o <= squash_o;
		end
	end

	// faulting address travels with the pulse
	always_ff @(posedge clock_i)
	begin
		if (squash_o)
			trapAddress_o <= stage1Address_i;
	end

endmodule

`default_nettype wire

// ==== flushTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module flushTimer
(
	input wire clock_i,
	input wire rstN_i,
	input wire load_i,
	output logic done_o
);

	localparam int CntW = ($clog2(`FLUSH_CYCLES) > 0) ? $clog2(`FLUSH_CYCLES) : 1;

	logic [CntW-1:0] count;

	// counts the remaining flush cycles down to zero
	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
			count <= '0;
		else if (load_i)
			count <= CntW'(`FLUSH_CYCLES - 1);
		else if (count != '0)
			count <= count - 1'b1;
	end

	assign done_o = (count == '0);

endmodule

`default_nettype wire

// ==== decodeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeUnit
(
	input wire clock_i,
	input wire rstN_i,
	input wire enable_i,
	input wire decodePkg::instrT instruction_i,
	input wire decodePkg::addrT instructionAddress_i,
	output logic enable_o,
	output decodePkg::immT imm_o,
	output logic immEnable_o,
	output decodePkg::regIdxT reg1_o,
	output decodePkg::regIdxT reg2_o,
	output decodePkg::regIdxT reg3_o,
	output logic reg1Enable_o,
	output logic reg2Enable_o,
	output logic reg3Enable_o,
	output logic reg2ValOrZero_o,
	output logic bit1_o,
	output logic bit2_o,
	output logic bit1Enable_o,
	output logic bit2Enable_o,
	output decodePkg::addrT instructionAddress_o,
	output decodePkg::opcodeT opcode_o,
	output decodePkg::xOpcodeT xOpcode_o,
	output logic xOpcodeEnable_o,
	output decodePkg::fuCodeT functionalUnitCode_o,
	output decodePkg::formatT instructionFormat_o,
	output logic trap_o,
	output decodePkg::addrT trapAddress_o,
	output logic stall_o
);

	logic capture;
	logic stage1Valid;
	logic illegal;
	logic squash;
	logic timerLoad;
	logic timerDone;
	decodePkg::addrT addressBypass;
	decodePkg::opcodeT opcodeBypass;

	formatIf dClaim ();
	formatIf xClaim ();

	// fetch is ignored during the flush window and the squash edge
	assign capture = enable_i && !stall_o && !squash;
	assign illegal = stage1Valid && !dClaim.claim && !xClaim.claim;

	//////////////////////////////////////////////////
	// stage one
	//////////////////////////////////////////////////
	dFormatDecoder dDecoder (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.capture_i(capture),
		.instruction_i(instruction_i),
		.claim(dClaim.decoder)
	);

	xFormatDecoder xDecoder (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.capture_i(capture),
		.instruction_i(instruction_i),
		.claim(xClaim.decoder)
	);

	always_ff @(posedge clock_i or negedge rstN_i)
	begin
		if (!rstN_i)
			stage1Valid <= 1'b0;
		else
			stage1Valid <= capture;
	end

	// address and opcode bypass the decoders
	always_ff @(posedge clock_i)
	begin
		if (capture)
		begin
			addressBypass <= instructionAddress_i;
			opcodeBypass <= instruction_i[0:5];
		end
	end

	//////////////////////////////////////////////////
	// stage two and trap control
	//////////////////////////////////////////////////
	decodeStage2 stage2 (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.stage1Valid_i(stage1Valid),
		.kill_i(squash),
		.stage1Address_i(addressBypass),
		.stage1Opcode_i(opcodeBypass),
		.dClaim(dClaim.mux),
		.xClaim(xClaim.mux),
		.enable_o(enable_o),
		.imm_o(imm_o),
		.immEnable_o(immEnable_o),
		.reg1_o(reg1_o),
		.reg2_o(reg2_o),
		.reg3_o(reg3_o),
		.reg1Enable_o(reg1Enable_o),
		.reg2Enable_o(reg2Enable_o),
		.reg3Enable_o(reg3Enable_o),
		.reg2ValOrZero_o(reg2ValOrZero_o),
		.bit1_o(bit1_o),
		.bit2_o(bit2_o),
		.bit1Enable_o(bit1Enable_o),
		.bit2Enable_o(bit2Enable_o),
		.instructionAddress_o(instructionAddress_o),
		.opcode_o(opcode_o),
		.xOpcode_o(xOpcode_o),
		.xOpcodeEnable_o(xOpcodeEnable_o),
		.functionalUnitCode_o(functionalUnitCode_o),
		.instructionFormat_o(instructionFormat_o)
	);

	decodeControl control (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.illegal_i(illegal),
		.stage1Address_i(addressBypass),
		.timerDone_i(timerDone),
		.timerLoad_o(timerLoad),
		.squash_o(squash),
		.trap_o(trap_o),
		.trapAddress_o(trapAddress_o),
		.stall_o(stall_o)
	);

	flushTimer timer (
		.clock_i(clock_i),
		.rstN_i(rstN_i),
		.load_i(timerLoad),
		.done_o(timerDone)
	);

endmodule

`default_nettype wire

// ==== decodeUnit_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeUnit_asserts
(
	input wire clock_i,
	input wire rstN_i,
	input wire dClaim_i,
	input wire xClaim_i,
	input wire enableOut_i,
	input wire trapOut_i
);

	// D and X decoders never claim the same word
	oneClaim: assert property (@(posedge clock_i) disable iff (!rstN_i)
		!(dClaim_i && xClaim_i))
		else $error("both stage-one decoders claimed one word");

	// trap is a single-cycle pulse
	trapPulse: assert property (@(posedge clock_i) disable iff (!rstN_i)
		trapOut_i |=> !trapOut_i)
		else $error("trap_o held high for more than one cycle");

	noRecordOnTrap: assert property (@(posedge clock_i) disable iff (!rstN_i)
		!(enableOut_i && trapOut_i))
		else $error("enable_o high together with trap_o");

endmodule

bind decodeUnit decodeUnit_asserts asserts (
	.clock_i(clock_i),
	.rstN_i(rstN_i),
	.dClaim_i(dClaim.claim),
	.xClaim_i(xClaim.claim),
	.enableOut_i(enable_o),
	.trapOut_i(trap_o)
);

`default_nettype wire

// ==== decodeUnit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decodeUnit_tb;

	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 5;
	localparam int NumTrans = 2000;
	localparam int DrainCycles = 8;
	// every transaction may cost a full flush window plus the pipeline
	localparam longint WatchdogNs = longint'(NumTrans) * (`FLUSH_CYCLES + 3) * ClockPeriod +
		ResetCycles * ClockPeriod;
	localparam logic [31:0] Seed = 32'h8cad_278c;

	// supported primary and extended opcodes by stimulus kind
	localparam decodePkg::opcodeT DOps [6] = '{6'd14, 6'd15, 6'd24, 6'd32, 6'd36, 6'd58};
	localparam decodePkg::xOpcodeT XOps [3] = '{10'd28, 10'd444, 10'd23};
	localparam logic [0:8] XoOps [2] = '{9'd266, 9'd40};

	typedef struct {
		decodePkg::immT imm;
		logic immEn;
		decodePkg::regIdxT reg1;
		decodePkg::regIdxT reg2;
		decodePkg::regIdxT reg3;
		logic reg1En;
		logic reg2En;
		logic reg3En;
		logic r2z;
		logic bit1;
		logic bit2;
		logic bitEn;
		decodePkg::addrT addr;
		decodePkg::opcodeT opcode;
		decodePkg::xOpcodeT xop;
		logic xopEn;
		decodePkg::fuCodeT fu;
		decodePkg::formatT fmt;
	} recordT;

	logic clock_i;
	logic rstN_i;
	logic enable_i;
	decodePkg::instrT instruction_i;
	decodePkg::addrT instructionAddress_i;
	logic enable_o;
	decodePkg::immT imm_o;
	logic immEnable_o;
	decodePkg::regIdxT reg1_o;
	decodePkg::regIdxT reg2_o;
	decodePkg::regIdxT reg3_o;
	logic reg1Enable_o;
	logic reg2Enable_o;
	logic reg3Enable_o;
	logic reg2ValOrZero_o;
	logic bit1_o;
	logic bit2_o;
	logic bit1Enable_o;
	logic bit2Enable_o;
	decodePkg::addrT instructionAddress_o;
	decodePkg::opcodeT opcode_o;
	decodePkg::xOpcodeT xOpcode_o;
	logic xOpcodeEnable_o;
	decodePkg::fuCodeT functionalUnitCode_o;
	decodePkg::formatT instructionFormat_o;
	logic trap_o;
	decodePkg::addrT trapAddress_o;
	logic stall_o;

	// reference model state
	recordT expQ [$];
	logic s1Valid;
	logic s1Legal;
	decodePkg::addrT s1Addr;
	int stallLeft;
	logic expEnable;
	logic expTrap;
	logic expStall;
	decodePkg::addrT expTrapAddr;
	int errorCount;

	decodeUnit dut (.*);

	always #(ClockPeriod / 2) clock_i = ~clock_i;

	task automatic reportFailure();
		begin
			errorCount++;
			$display("Finished with errors");
			$fatal(1, "simulation stopped at the first error");
		end
	endtask

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////
	task automatic checkImm(input string name, input decodePkg::immT got,
		input decodePkg::immT exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkReg(input string name, input decodePkg::regIdxT got,
		input decodePkg::regIdxT exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got %0d expected %0d", $time, name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkAddr(input string name, input decodePkg::addrT got,
		input decodePkg::addrT exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkUnit(input string name, input decodePkg::fuCodeT got,
		input decodePkg::fuCodeT exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got %0d expected %0d", $time, name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkFormat(input string name, input decodePkg::formatT got,
		input decodePkg::formatT exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got %0d expected %0d", $time, name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkXOpcode(input string name, input decodePkg::xOpcodeT got,
		input decodePkg::xOpcodeT exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got %0d expected %0d", $time, name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkOpcode(input string name, input decodePkg::opcodeT got,
		input decodePkg::opcodeT exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got %0d expected %0d", $time, name, got, exp);
			reportFailure();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL time %0t %s got %b expected %b", $time, name, got, exp);
			reportFailure();
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus and reference decode
	//////////////////////////////////////////////////

	// kinds 0..10 are the supported encodings, 11 to 13 are illegal
	function automatic decodePkg::instrT makeWord(input int kind);
		decodePkg::instrT w;
		decodePkg::opcodeT op;
		begin
			w = $urandom;
			if (kind < 6)
			begin
				w[0:5] = DOps[kind];
				if (kind == 5)
					w[30:31] = 2'b00;
			end
			else if (kind < 9)
			begin
				w[0:5] = 6'd31;
				w[21:30] = XOps[kind - 6];
			end
			else if (kind < 11)
			begin
				w[0:5] = 6'd31;
				w[22:30] = XoOps[kind - 9];
			end
			else if (kind == 11)
			begin
				do
					op = 6'($urandom);
				while (op inside {6'd14, 6'd15, 6'd24, 6'd31, 6'd32, 6'd36, 6'd58});
				w[0:5] = op;
			end
			else if (kind == 12)
			begin
				// ld opcode with a reserved DS sub-opcode
				w[0:5] = 6'd58;
				w[30:31] = 2'(1 + $urandom % 3);
			end
			else
			begin
				// opcode 31 with an unsupported extended opcode
				w[0:5] = 6'd31;
				while ((w[21:30] inside {10'd28, 10'd444, 10'd23}) ||
					(w[22:30] inside {9'd266, 9'd40}))
					w[21:30] = 10'($urandom);
			end
			return w;
		end
	endfunction

	function automatic logic decodeWord(input decodePkg::instrT w, input decodePkg::addrT a,
		output recordT rec);
		decodePkg::rawImmT raw;
		decodePkg::xOpcodeT xo10;
		logic [0:8] xo9;
		logic legal;
		begin
			rec = '{default: '0};
			raw = w[16:31];
			xo10 = w[21:30];
			xo9 = w[22:30];
			legal = 1'b1;
			rec.addr = a;
			rec.opcode = w[0:5];
			rec.reg1 = w[6:10];
			rec.reg2 = w[11:15];
			rec.reg1En = 1'b1;
			rec.reg2En = 1'b1;
			rec.fu = decodePkg::FX_UNIT;
			case (w[0:5])
				6'd14, 6'd15, 6'd24, 6'd32, 6'd36:
				begin
					rec.fmt = decodePkg::FMT_D;
					rec.immEn = 1'b1;
					// RA|0 for everything but the logical immediate
					rec.r2z = (w[0:5] != 6'd24);
					if (w[0:5] == 6'd24)
						rec.imm = decodePkg::immT'(raw);
					else if (w[0:5] == 6'd15)
						rec.imm = decodePkg::immT'($signed(raw)) << 16;
					else
						rec.imm = decodePkg::immT'($signed(raw));
					if ((w[0:5] == 6'd32) || (w[0:5] == 6'd36))
						rec.fu = decodePkg::LDST_UNIT;
				end
				6'd58:
				begin
					legal = (w[30:31] == 2'b00);
					rec.fmt = decodePkg::FMT_DS;
					rec.immEn = 1'b1;
					rec.r2z = 1'b1;
					rec.imm = decodePkg::immT'($signed({raw[0:13], 2'b00}));
					rec.fu = decodePkg::LDST_UNIT;
				end
				6'd31:
				begin
					rec.reg3 = w[16:20];
					rec.reg3En = 1'b1;
					rec.xopEn = 1'b1;
					if (xo10 inside {10'd28, 10'd444, 10'd23})
					begin
						rec.fmt = decodePkg::FMT_X;
						rec.xop = xo10;
						rec.r2z = (xo10 == 10'd23);
						if (xo10 == 10'd23)
							rec.fu = decodePkg::LDST_UNIT;
					end
					else if (xo9 inside {9'd266, 9'd40})
					begin
						rec.fmt = decodePkg::FMT_XO;
						rec.xop = {1'b0, xo9};
						rec.bitEn = 1'b1;
						rec.bit1 = w[21];
						rec.bit2 = w[31];
					end
					else
						legal = 1'b0;
				end
				default:
					legal = 1'b0;
			endcase
			return legal;
		end
	endfunction

	task automatic driveRandom();
		int pick;
		begin
			pick = $urandom % 32;
			enable_i = (pick >= 3);
			instructionAddress_i = {$urandom, $urandom} & ~64'h3;
			if (pick == 3)
				instruction_i = makeWord(11);
			else if (pick == 4)
				instruction_i = makeWord(12);
			else if (pick == 5)
				instruction_i = makeWord(13);
			else
				instruction_i = makeWord($urandom % 11);
		end
	endtask

	// one rising edge of the reference pipeline
	task automatic stepModel();
		logic squashNow;
		logic takeNow;
		logic legal;
		recordT rec;
		begin
			squashNow = s1Valid && !s1Legal;
			takeNow = enable_i && (stallLeft == 0) && !squashNow;
			expEnable = s1Valid && s1Legal;
			expTrap = squashNow;
			if (squashNow)
			begin
				expTrapAddr = s1Addr;
				stallLeft = `FLUSH_CYCLES;
			end
			else if (stallLeft > 0)
				stallLeft--;
			expStall = (stallLeft > 0);
			s1Valid = takeNow;
			if (takeNow)
			begin
				legal = decodeWord(instruction_i, instructionAddress_i, rec);
				s1Legal = legal;
				s1Addr = instructionAddress_i;
				if (legal)
					expQ.push_back(rec);
			end
		end
	endtask

	task automatic checkOutputs();
		recordT exp;
		begin
			exp = '{default: '0};
			if (expEnable)
				exp = expQ.pop_front();
			checkFlag("enable_o", enable_o, expEnable);
			checkFlag("trap_o", trap_o, expTrap);
			checkFlag("stall_o", stall_o, expStall);
			if (expTrap)
				checkAddr("trapAddress_o", trapAddress_o, expTrapAddr);
			checkFlag("immEnable_o", immEnable_o, exp.immEn);
			checkFlag("reg1Enable_o", reg1Enable_o, exp.reg1En);
			checkFlag("reg2Enable_o", reg2Enable_o, exp.reg2En);
			checkFlag("reg3Enable_o", reg3Enable_o, exp.reg3En);
			checkFlag("bit1Enable_o", bit1Enable_o, exp.bitEn);
			checkFlag("bit2Enable_o", bit2Enable_o, exp.bitEn);
			checkFlag("xOpcodeEnable_o", xOpcodeEnable_o, exp.xopEn);
			if (expEnable)
			begin
				if (exp.immEn)
					checkImm("imm_o", imm_o, exp.imm);
				checkReg("reg1_o", reg1_o, exp.reg1);
				checkReg("reg2_o", reg2_o, exp.reg2);
				if (exp.reg3En)
					checkReg("reg3_o", reg3_o, exp.reg3);
				checkFlag("reg2ValOrZero_o", reg2ValOrZero_o, exp.r2z);
				if (exp.bitEn)
				begin
					checkFlag("bit1_o", bit1_o, exp.bit1);
					checkFlag("bit2_o", bit2_o, exp.bit2);
				end
				checkAddr("instructionAddress_o", instructionAddress_o, exp.addr);
				checkOpcode("opcode_o", opcode_o, exp.opcode);
				if (exp.xopEn)
					checkXOpcode("xOpcode_o", xOpcode_o, exp.xop);
				checkUnit("functionalUnitCode_o", functionalUnitCode_o, exp.fu);
				checkFormat("instructionFormat_o", instructionFormat_o, exp.fmt);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence and watchdog
	//////////////////////////////////////////////////
	initial
	begin
		void'($urandom(Seed));
		clock_i = 1'b0;
		rstN_i = 1'b0;
		enable_i = 1'b0;
		instruction_i = '0;
		instructionAddress_i = '0;
		s1Valid = 1'b0;
		s1Legal = 1'b0;
		s1Addr = '0;
		stallLeft = 0;
		expEnable = 1'b0;
		expTrap = 1'b0;
		expStall = 1'b0;
		expTrapAddr = '0;
		errorCount = 0;
		repeat (ResetCycles) @(negedge clock_i);
		// control outputs must be quiet out of reset
		checkOutputs();
		rstN_i = 1'b1;
		for (int cyc = 0; cyc < NumTrans + DrainCycles; cyc++)
		begin
			if (cyc < NumTrans)
				driveRandom();
			else
				enable_i = 1'b0;
			@(posedge clock_i);
			stepModel();
			@(negedge clock_i);
			checkOutputs();
		end
		if (expQ.size() != 0)
		begin
			$display("%0d decoded records were never output", expQ.size());
			errorCount++;
		end
		if (errorCount == 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
			reportFailure();
	end

	initial
	begin
		#(WatchdogNs);
		$display("timeout, the run did not complete within %0d ns", WatchdogNs);
		reportFailure();
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
decodePkg.sv
formatIf.sv
dFormatDecoder.sv
xFormatDecoder.sv
decodeStage2.sv
decodeControl.sv
flushTimer.sv
decodeUnit.sv
decodeUnit_asserts.sv
decodeUnit_tb.sv

// ==== Bender.yml ====
package:
  name: decode_unit

export_include_dirs:
  - .

sources:
  - decodePkg.sv
  - formatIf.sv
  - dFormatDecoder.sv
  - xFormatDecoder.sv
  - decodeStage2.sv
  - decodeControl.sv
  - flushTimer.sv
  - decodeUnit.sv
  - target: test
    files:
      - decodeUnit_asserts.sv
      - decodeUnit_tb.sv
